// File: source/lsu_pkg.sv
// shared widths for the load/store unit
// access size encoding and the decoded byte address view
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // data bus and register width
  localparam int unsigned DataWidth   = 32;
  // one enable per byte lane
  localparam int unsigned BeWidth     = DataWidth / 8;
  // byte offset inside a word
  localparam int unsigned OffsetWidth = 2;

  ////////////////////////////////////////
  // access size
  ////////////////////////////////////////

  // 2'b11 is not a legal size and is never captured
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  ////////////////////////////////////////
  // byte address, two views
  ////////////////////////////////////////

  // word index over byte offset
  typedef struct packed {
    logic [DataWidth-OffsetWidth-1:0] word_idx;
    logic [OffsetWidth-1:0]           offset;
  } lsu_addr_fields_t;

  // flat byte address, or split into word index and offset
  typedef union packed {
    logic [DataWidth-1:0] flat;
    lsu_addr_fields_t     fields;
  } lsu_addr_u;

endpackage

`default_nettype wire

// File: source/lsu_wdata_align.sv
// byte enable generation for each access size and part
// write data rotation into lane position
`timescale 1ns/100ps
`default_nettype none

module lsu_wdata_align (
  input  lsu_pkg::lsu_type_e              type_i,
  input  logic [lsu_pkg::OffsetWidth-1:0] offset_i,
  input  logic                            second_part_i,
  input  logic [lsu_pkg::DataWidth-1:0]   wdata_i,
  output logic [lsu_pkg::BeWidth-1:0]     data_be_o,
  output logic [lsu_pkg::DataWidth-1:0]   data_wdata_o
);
  import lsu_pkg::*;

  // two copies side by side so a shift acts as a rotate
  logic [2*DataWidth-1:0] wdata_dbl;

  // first part enables start at the offset lane and run upward,
  // second part enables cover the bytes that spilled over
  always_comb begin
    unique case (type_i)
      LSU_WORD: begin
        if (!second_part_i) begin
          data_be_o = 4'b1111 << offset_i;
        end else begin
          // spilled bytes fill the low lanes, an aligned word has none
          data_be_o = 4'b1111 >> (3'd4 - offset_i);
        end
      end
      LSU_HALF: begin
        // only offset 3 reaches a second part, which holds the top byte
        data_be_o = second_part_i ? 4'b0001 : 4'b0011 << offset_i;
      end
      LSU_BYTE: data_be_o = 4'b0001 << offset_i;
      default:  data_be_o = 4'b1111;
    endcase
  end

  // rotate left by offset bytes, same lanes serve both parts
  assign wdata_dbl    = {wdata_i, wdata_i} << {offset_i, 3'b000};
  assign data_wdata_o = wdata_dbl[2*DataWidth-1:DataWidth];

  // an access with no enabled lane would write nothing
  be_nonzero_a: assert final (data_be_o != '0);

endmodule

`default_nettype wire

// File: source/lsu_rdata_align.sv
// first part read data register for split loads
// word and half word realignment, byte extraction, sign extension
`timescale 1ns/100ps
`default_nettype none

module lsu_rdata_align (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            rdata_capture_i,
  input  lsu_pkg::lsu_type_e              type_i,
  input  logic [lsu_pkg::OffsetWidth-1:0] offset_i,
  input  logic                            sign_ext_i,
  input  logic [lsu_pkg::DataWidth-1:0]   data_rdata_i,
  output logic [lsu_pkg::DataWidth-1:0]   lsu_rdata_o
);
  import lsu_pkg::*;

  // upper three bytes of the first word, the lowest byte is never needed
  logic [DataWidth-1:8] rdata_q;

  logic [DataWidth-1:0] word_val;
  logic [15:0]          half_val;
  logic [7:0]           byte_val;
  logic [DataWidth-1:0] half_ext;
  logic [DataWidth-1:0] byte_ext;

  ////////////////////////////////////////
  // first part capture
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rdata_capture_i) begin
      rdata_q <= data_rdata_i[DataWidth-1:8];
    end
  end

  ////////////////////////////////////////
  // realignment
  ////////////////////////////////////////

  // unaligned words take the low bytes from the second response
  always_comb begin
    unique case (offset_i)
      2'b00: word_val = data_rdata_i;
      2'b01: word_val = {data_rdata_i[7:0], rdata_q[31:8]};
      2'b10: word_val = {data_rdata_i[15:0], rdata_q[31:16]};
      2'b11: word_val = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // half word at offset 3 straddles both responses
  always_comb begin
    unique case (offset_i)
      2'b00: half_val = data_rdata_i[15:0];
      2'b01: half_val = data_rdata_i[23:8];
      2'b10: half_val = data_rdata_i[31:16];
      2'b11: half_val = {data_rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  // a byte always sits in a single response
  assign byte_val = data_rdata_i[{offset_i, 3'b000} +: 8];

  ////////////////////////////////////////
  // extension
  ////////////////////////////////////////

  // sign comes from the top bit of the extracted value
  assign half_ext = {{16{sign_ext_i & half_val[15]}}, half_val};
  assign byte_ext = {{24{sign_ext_i & byte_val[7]}}, byte_val};

  always_comb begin
    unique case (type_i)
      LSU_HALF: lsu_rdata_o = half_ext;
      LSU_BYTE: lsu_rdata_o = byte_ext;
      default:  lsu_rdata_o = word_val;
    endcase
  end

  // the captured bytes are picked by offset on the later response
  offset_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rdata_capture_i |-> !$isunknown(offset_i));

endmodule

`default_nettype wire

// File: source/lsu_ctrl_fsm.sv
// bus sequencing FSM for one load or store at a time
// request capture, split decision, last address and response pulses
`timescale 1ns/100ps
`default_nettype none

module lsu_ctrl_fsm (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // core side
  input  logic                             lsu_req_i,
  input  logic                             lsu_we_i,
  input  lsu_pkg::lsu_type_e               lsu_type_i,
  input  logic                             lsu_sign_ext_i,
  input  logic [lsu_pkg::DataWidth-1:0]    lsu_addr_i,
  input  logic [lsu_pkg::DataWidth-1:0]    lsu_wdata_i,
  output logic                             busy_o,
  // bus side
  output logic                             data_req_o,
  input  logic                             data_gnt_i,
  output logic [lsu_pkg::DataWidth-1:0]    data_addr_o,
  output logic                             data_we_o,
  input  logic                             data_rvalid_i,
  input  logic                             data_err_i,
  // to the align blocks
  output lsu_pkg::lsu_type_e               type_q_o,
  output logic [lsu_pkg::OffsetWidth-1:0]  offset_q_o,
  output logic                             sign_ext_q_o,
  output logic [lsu_pkg::DataWidth-1:0]    wdata_q_o,
  output logic                             second_part_o,
  output logic                             rdata_capture_o,
  // response and errors
  output logic                             lsu_resp_valid_o,
  output logic                             lsu_rdata_valid_o,
  output logic                             load_err_o,
  output logic                             store_err_o,
  output logic [lsu_pkg::DataWidth-1:0]    addr_last_o
);
  import lsu_pkg::*;

  typedef enum logic [2:0] {
    IDLE, REQ_FIRST, WAIT_FIRST, REQ_SECOND, WAIT_LAST
  } state_e;

  state_e                 state_q, state_d;
  lsu_addr_u              req_addr;
  lsu_addr_u              addr_q;
  logic [DataWidth-1:0]   next_word_addr;
  logic [DataWidth-1:0]   addr_last_q;
  logic [DataWidth-1:0]   wdata_q;
  logic [OffsetWidth-1:0] offset_q;
  lsu_type_e              type_q;
  logic                   we_q, sign_ext_q, split_q;
  logic                   split_req, accept, first_gnt, second_gnt, final_rsp;

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  assign req_addr.flat = lsu_addr_i;
  assign accept        = (state_q == IDLE) & lsu_req_i;

  // words off a word boundary, or a half word in the top lane, need two accesses
  assign split_req = ((lsu_type_i == LSU_WORD) && (req_addr.fields.offset != 2'b00)) ||
                     ((lsu_type_i == LSU_HALF) && (req_addr.fields.offset == 2'b11));

  // second access goes to the following word, wrapping at the top
  assign next_word_addr = {addr_q.fields.word_idx + 1'b1, {OffsetWidth{1'b0}}};

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      we_q        <= 1'b0;
      type_q      <= LSU_WORD;
      offset_q    <= '0;
      sign_ext_q  <= 1'b0;
      split_q     <= 1'b0;
      addr_last_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        we_q       <= lsu_we_i;
        type_q     <= lsu_type_i;
        offset_q   <= req_addr.fields.offset;
        sign_ext_q <= lsu_sign_ext_i;
        split_q    <= split_req;
      end
      // byte address on the first grant, next word on the second
      if (first_gnt) begin
        addr_last_q <= addr_q.flat;
      end else if (second_gnt) begin
        addr_last_q <= next_word_addr;
      end
    end
  end

  // address and store data held for the whole transaction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= req_addr;
      wdata_q <= lsu_wdata_i;
    end
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    data_req_o    = 1'b0;
    second_part_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (lsu_req_i) begin
          state_d = REQ_FIRST;
        end
      end
      REQ_FIRST: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          state_d = split_q ? WAIT_FIRST : WAIT_LAST;
        end
      end
      WAIT_FIRST: begin
        // an error here ends the transaction, second part skipped
        if (data_rvalid_i) begin
          state_d = data_err_i ? IDLE : REQ_SECOND;
        end
      end
      REQ_SECOND: begin
        data_req_o    = 1'b1;
        second_part_o = 1'b1;
        if (data_gnt_i) begin
          state_d = WAIT_LAST;
        end
      end
      WAIT_LAST: begin
        if (data_rvalid_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign first_gnt  = (state_q == REQ_FIRST) & data_gnt_i;
  assign second_gnt = (state_q == REQ_SECOND) & data_gnt_i;

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign busy_o      = (state_q != IDLE);
  assign data_we_o   = we_q;
  assign data_addr_o = second_part_o ? next_word_addr
                                     : {addr_q.fields.word_idx, {OffsetWidth{1'b0}}};

  assign type_q_o     = type_q;
  assign offset_q_o   = offset_q;
  assign sign_ext_q_o = sign_ext_q;
  assign wdata_q_o    = wdata_q;

  // keep the first word of a clean split load
  assign rdata_capture_o = (state_q == WAIT_FIRST) & data_rvalid_i & ~data_err_i & ~we_q;

  // last response, or a first part that failed
  assign final_rsp = data_rvalid_i &
                     ((state_q == WAIT_LAST) | ((state_q == WAIT_FIRST) & data_err_i));

  assign lsu_resp_valid_o  = final_rsp;
  assign lsu_rdata_valid_o = final_rsp & ~we_q & ~data_err_i;
  assign load_err_o        = final_rsp & data_err_i & ~we_q;
  assign store_err_o       = final_rsp & data_err_i & we_q;
  assign addr_last_o       = addr_last_q;

  // bus only ever sees word aligned addresses
  addr_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_addr_o[OffsetWidth-1:0] == '0));

  no_req_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == IDLE) |-> !data_req_o);

  type_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    type_q inside {LSU_WORD, LSU_HALF, LSU_BYTE});

endmodule

`default_nettype wire

// File: source/lsu_top.sv
// load/store unit top level
// connects the control FSM and both align blocks to core and bus
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // core side
  input  logic                           lsu_req_i,
  input  logic                           lsu_we_i,
  input  lsu_pkg::lsu_type_e             lsu_type_i,
  input  logic                           lsu_sign_ext_i,
  input  logic [lsu_pkg::DataWidth-1:0]  lsu_addr_i,
  input  logic [lsu_pkg::DataWidth-1:0]  lsu_wdata_i,
  output logic                           busy_o,
  output logic                           lsu_resp_valid_o,
  output logic                           lsu_rdata_valid_o,
  output logic [lsu_pkg::DataWidth-1:0]  lsu_rdata_o,
  output logic                           load_err_o,
  output logic                           store_err_o,
  output logic [lsu_pkg::DataWidth-1:0]  addr_last_o,
  // data bus
  output logic                           data_req_o,
  input  logic                           data_gnt_i,
  output logic [lsu_pkg::DataWidth-1:0]  data_addr_o,
  output logic                           data_we_o,
  output logic [lsu_pkg::BeWidth-1:0]    data_be_o,
  output logic [lsu_pkg::DataWidth-1:0]  data_wdata_o,
  input  logic                           data_rvalid_i,
  input  logic [lsu_pkg::DataWidth-1:0]  data_rdata_i,
  input  logic                           data_err_i
);
  import lsu_pkg::*;

  // registered request fields shared by both align blocks
  lsu_type_e              type_q;
  logic [OffsetWidth-1:0] offset_q;
  logic                   sign_ext_q;
  logic [DataWidth-1:0]   wdata_q;
  logic                   second_part;
  logic                   rdata_capture;

  lsu_ctrl_fsm lsu_ctrl_fsm_inst (
    .clk_i, .rst_ni,
    .lsu_req_i, .lsu_we_i, .lsu_type_i, .lsu_sign_ext_i, .lsu_addr_i, .lsu_wdata_i,
    .busy_o,
    .data_req_o, .data_gnt_i, .data_addr_o, .data_we_o, .data_rvalid_i, .data_err_i,
    .type_q_o        (type_q),
    .offset_q_o      (offset_q),
    .sign_ext_q_o    (sign_ext_q),
    .wdata_q_o       (wdata_q),
    .second_part_o   (second_part),
    .rdata_capture_o (rdata_capture),
    .lsu_resp_valid_o, .lsu_rdata_valid_o, .load_err_o, .store_err_o, .addr_last_o
  );

  // store path
  lsu_wdata_align lsu_wdata_align_inst (
    .type_i        (type_q),
    .offset_i      (offset_q),
    .second_part_i (second_part),
    .wdata_i       (wdata_q),
    .data_be_o,
    .data_wdata_o
  );

  // load path
  lsu_rdata_align lsu_rdata_align_inst (
    .clk_i, .rst_ni,
    .rdata_capture_i (rdata_capture),
    .type_i          (type_q),
    .offset_i        (offset_q),
    .sign_ext_i      (sign_ext_q),
    .data_rdata_i,
    .lsu_rdata_o
  );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// testbench clock and reset source
// 4 ns clock, active low reset held for 10 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // half period of 2 ns
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // release on a rising edge, like any other stimulus
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_lsu_top.sv
// testbench for the load/store unit
// bus memory model with random wait states, reference byte model
// directed tests for aligned, sub-word, split, random and error accesses
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_top;
  import lsu_pkg::*;

  // about 300 transactions of up to 20 cycles each
  localparam int TimeoutCycles = 6000;
  localparam int HangCycles    = 64;
  localparam int AccLogDepth   = 1024;
  localparam logic [31:0] LfsrSeed = 32'h9059_c153;

  logic        clk_i;
  logic        rst_ni;
  logic        lsu_req_i;
  logic        lsu_we_i;
  lsu_type_e   lsu_type_i;
  logic        lsu_sign_ext_i;
  logic [31:0] lsu_addr_i;
  logic [31:0] lsu_wdata_i;
  logic        busy_o;
  logic        lsu_resp_valid_o;
  logic        lsu_rdata_valid_o;
  logic [31:0] lsu_rdata_o;
  logic        load_err_o;
  logic        store_err_o;
  logic [31:0] addr_last_o;
  logic        data_req_o;
  logic        data_gnt_i;
  logic [31:0] data_addr_o;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_wdata_o;
  logic        data_rvalid_i;
  logic [31:0] data_rdata_i;
  logic        data_err_i;

  // bus model state, written only by the bus model process
  logic [31:0] mem [0:255];
  logic [31:0] acc_addr [0:AccLogDepth-1];
  logic [3:0]  acc_be [0:AccLogDepth-1];
  logic        acc_we [0:AccLogDepth-1];
  int          acc_count;
  int          bus_fail_count;
  logic [31:0] bus_lfsr_q;
  logic [31:0] held_addr;
  logic [31:0] held_wdata;
  logic [3:0]  held_be;
  logic        held_we;

  // stimulus side state
  logic [7:0]  ref_mem [0:1023];
  logic [31:0] stim_lfsr_q;
  string       test_name;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          test_err_start;
  int          acc_start;
  logic        res_done;
  logic        res_rdata_valid;
  logic        res_load_err;
  logic        res_store_err;
  logic [31:0] res_rdata;
  logic [31:0] res_addr_last;
  int          res_accesses;

  tb_clk_gen tb_clk_gen_inst (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  lsu_top lsu_top_inst (.*);

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      val   = {val[30:0], state[0]};
    end
  endtask

  // initial memory contents, every address bit takes part
  function automatic logic [7:0] fill_byte(input logic [9:0] a);
    return a[7:0] ^ {4{a[9:8]}} ^ 8'h5a;
  endfunction

  function automatic int access_size(input lsu_type_e typ);
    case (typ)
      LSU_HALF: return 2;
      LSU_BYTE: return 1;
      default:  return 4;
    endcase
  endfunction

  // little endian read from the reference, then extension by size
  function automatic logic [31:0] expect_load(input lsu_type_e typ, input logic sext,
                                              input logic [31:0] addr);
    logic [31:0] raw;
    for (int i = 0; i < 4; i++) begin
      raw[8*i +: 8] = ref_mem[(addr + i) % 1024];
    end
    case (typ)
      LSU_HALF: return {{16{sext & raw[15]}}, raw[15:0]};
      LSU_BYTE: return {{24{sext & raw[7]}}, raw[7:0]};
      default:  return raw;
    endcase
  endfunction

  task automatic store_ref(input lsu_type_e typ, input logic [31:0] addr,
                           input logic [31:0] wdata);
    for (int i = 0; i < access_size(typ); i++) begin
      ref_mem[(addr + i) % 1024] = wdata[8*i +: 8];
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s: %s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = errors + bus_fail_count;
  endtask

  task automatic finish_test();
    int errs;
    errs = errors + bus_fail_count - test_err_start;
    tests_run++;
    if (errs == 0) begin
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, errs);
    end
  endtask

  ////////////////////////////////////////
  // access driver
  ////////////////////////////////////////

  // one request, then wait for the response with a hang limit
  task automatic run_access(input logic we, input lsu_type_e typ, input logic sext,
                            input logic [31:0] addr, input logic [31:0] wdata);
    int waited;
    acc_start = acc_count;
    res_done  = 1'b0;
    waited    = 0;
    @(posedge clk_i);
    lsu_req_i      <= 1'b1;
    lsu_we_i       <= we;
    lsu_type_i     <= typ;
    lsu_sign_ext_i <= sext;
    lsu_addr_i     <= addr;
    lsu_wdata_i    <= wdata;
    @(posedge clk_i);
    check_value("busy at acceptance", 32'd0, {31'd0, busy_o});
    // request fields are captured, scramble them to prove it
    lsu_req_i      <= 1'b0;
    lsu_we_i       <= ~we;
    lsu_type_i     <= (typ == LSU_WORD) ? LSU_BYTE : LSU_WORD;
    lsu_sign_ext_i <= ~sext;
    lsu_addr_i     <= ~addr;
    lsu_wdata_i    <= ~wdata;
    while (!res_done && waited < HangCycles) begin
      @(posedge clk_i);
      waited++;
      check_value("busy during access", 32'd1, {31'd0, busy_o});
      if (lsu_resp_valid_o) begin
        res_done        = 1'b1;
        res_rdata       = lsu_rdata_o;
        res_rdata_valid = lsu_rdata_valid_o;
        res_load_err    = load_err_o;
        res_store_err   = store_err_o;
      end
    end
    if (!res_done) begin
      errors++;
      $display("%s: hang, no response within %0d cycles at address 0x%08h",
               test_name, HangCycles, addr);
    end else begin
      @(posedge clk_i);
      // response is a single pulse and busy drops right after it
      check_value("response pulse length", 32'd0, {31'd0, lsu_resp_valid_o});
      check_value("busy after response", 32'd0, {31'd0, busy_o});
      res_addr_last = addr_last_o;
      res_accesses  = acc_count - acc_start;
    end
  endtask

  // full check of an error free access against the reference
  task automatic check_access(input logic we, input lsu_type_e typ, input logic sext,
                              input logic [31:0] addr, input logic [31:0] wdata);
    lsu_addr_u   a;
    logic [31:0] exp_rdata;
    logic [31:0] word0;
    logic [31:0] word1;
    logic [7:0]  exp_mask;
    logic [7:0]  act_mask;
    int          size;
    logic        split;
    a.flat    = addr;
    size      = access_size(typ);
    // bytes running past lane 3 need a second word
    split     = (int'(a.fields.offset) + size) > 4;
    exp_rdata = expect_load(typ, sext, addr);
    word0     = {a.fields.word_idx, 2'b00};
    word1     = {a.fields.word_idx + 30'd1, 2'b00};
    exp_mask  = 8'(((1 << size) - 1) << a.fields.offset);
    run_access(we, typ, sext, addr, wdata);
    if (res_done) begin
      check_value("error flags", 32'd0, {30'd0, res_load_err, res_store_err});
      check_value("read data valid", {31'd0, ~we}, {31'd0, res_rdata_valid});
      if (!we) begin
        check_value("read data", exp_rdata, res_rdata);
      end else begin
        store_ref(typ, addr, wdata);
      end
      check_value("bus accesses", split ? 32'd2 : 32'd1, res_accesses);
      check_value("first bus address", word0, acc_addr[acc_start % AccLogDepth]);
      check_value("bus write enable", {31'd0, we}, {31'd0, acc_we[acc_start % AccLogDepth]});
      act_mask = {4'b0000, acc_be[acc_start % AccLogDepth]};
      if (split) begin
        check_value("second bus address", word1, acc_addr[(acc_start + 1) % AccLogDepth]);
        act_mask = act_mask | {acc_be[(acc_start + 1) % AccLogDepth], 4'b0000};
      end
      check_value("byte enable cover", {24'd0, exp_mask}, {24'd0, act_mask});
      check_value("last address", split ? word1 : addr, res_addr_last);
    end
  endtask

  task automatic check_error_response(input logic exp_load_err, input logic exp_store_err,
                                      input int exp_accesses, input logic [31:0] exp_last);
    if (res_done) begin
      check_value("load error", {31'd0, exp_load_err}, {31'd0, res_load_err});
      check_value("store error", {31'd0, exp_store_err}, {31'd0, res_store_err});
      check_value("read data valid", 32'd0, {31'd0, res_rdata_valid});
      check_value("bus accesses", exp_accesses, res_accesses);
      check_value("last address", exp_last, res_addr_last);
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic reset_values();
    start_test("reset values");
    check_value("control outputs", 32'd0, {26'd0, data_req_o, busy_o, lsu_resp_valid_o,
                                           lsu_rdata_valid_o, load_err_o, store_err_o});
    check_value("last address", 32'd0, addr_last_o);
    finish_test();
  endtask

  task automatic aligned_word();
    start_test("aligned word");
    check_access(1'b1, LSU_WORD, 1'b0, 32'h40, 32'h1234_5678);
    check_access(1'b0, LSU_WORD, 1'b0, 32'h40, 32'h0);
    finish_test();
  endtask

  task automatic sub_word_access();
    start_test("sub-word access");
    // each store read back as a whole word
    for (int off = 0; off < 4; off++) begin
      check_access(1'b1, LSU_BYTE, 1'b0, 32'h80 + off, 32'h5511_22c0 + off);
      check_access(1'b0, LSU_WORD, 1'b0, 32'h80, 32'h0);
    end
    for (int off = 0; off < 3; off++) begin
      check_access(1'b1, LSU_HALF, 1'b0, 32'h90 + off, 32'hbeef_9a00 + off);
      check_access(1'b0, LSU_WORD, 1'b0, 32'h90, 32'h0);
    end
    // mix of positive and negative bytes and halves
    check_access(1'b1, LSU_WORD, 1'b0, 32'ha0, 32'h8af0_7f81);
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        check_access(1'b0, LSU_BYTE, s[0], 32'ha0 + off, 32'h0);
      end
    end
    for (int off = 0; off < 3; off++) begin
      for (int s = 0; s < 2; s++) begin
        check_access(1'b0, LSU_HALF, s[0], 32'ha0 + off, 32'h0);
      end
    end
    finish_test();
  endtask

  task automatic split_access();
    start_test("split access");
    check_access(1'b1, LSU_WORD, 1'b0, 32'hc1, 32'h1122_3344);
    check_access(1'b1, LSU_WORD, 1'b0, 32'hca, 32'h5566_7788);
    check_access(1'b1, LSU_WORD, 1'b0, 32'hd3, 32'h99aa_bbcc);
    check_access(1'b1, LSU_HALF, 1'b0, 32'hdb, 32'h0000_f00d);
    check_access(1'b0, LSU_WORD, 1'b0, 32'hc1, 32'h0);
    check_access(1'b0, LSU_WORD, 1'b0, 32'hc4, 32'h0);
    check_access(1'b0, LSU_WORD, 1'b0, 32'hca, 32'h0);
    check_access(1'b0, LSU_WORD, 1'b0, 32'hd3, 32'h0);
    check_access(1'b0, LSU_HALF, 1'b1, 32'hdb, 32'h0);
    check_access(1'b0, LSU_HALF, 1'b0, 32'hdb, 32'h0);
    finish_test();
  endtask

  task automatic random_traffic();
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic        sext;
    lsu_type_e   typ;
    start_test("random traffic");
    for (int n = 0; n < 200; n++) begin
      draw_bits(stim_lfsr_q, 10, rnd);
      // stay clear of the error region, split accesses included
      addr = (rnd >= 32'h2f8) ? rnd - 32'h200 : rnd;
      draw_bits(stim_lfsr_q, 1, rnd);
      we = rnd[0];
      draw_bits(stim_lfsr_q, 2, rnd);
      case (rnd[1:0])
        2'b00:   typ = LSU_WORD;
        2'b01:   typ = LSU_HALF;
        default: typ = LSU_BYTE;
      endcase
      draw_bits(stim_lfsr_q, 1, rnd);
      sext = rnd[0];
      draw_bits(stim_lfsr_q, 32, wdata);
      check_access(we, typ, sext, addr, wdata);
    end
    finish_test();
  endtask

  task automatic error_responses();
    start_test("bus errors");
    run_access(1'b0, LSU_WORD, 1'b0, 32'h310, 32'h0);
    check_error_response(1'b1, 1'b0, 1, 32'h310);
    run_access(1'b1, LSU_BYTE, 1'b0, 32'h321, 32'h0000_00a5);
    check_error_response(1'b0, 1'b1, 1, 32'h321);
    // first part fails, second part never requested
    run_access(1'b0, LSU_WORD, 1'b0, 32'h33d, 32'h0);
    check_error_response(1'b1, 1'b0, 1, 32'h33d);
    run_access(1'b1, LSU_WORD, 1'b0, 32'h302, 32'hcafe_f00d);
    check_error_response(1'b0, 1'b1, 1, 32'h302);
    // only the second word sits in the region
    run_access(1'b0, LSU_WORD, 1'b0, 32'h2fe, 32'h0);
    check_error_response(1'b1, 1'b0, 2, 32'h300);
    check_access(1'b0, LSU_WORD, 1'b0, 32'h40, 32'h0);
    finish_test();
  endtask

  ////////////////////////////////////////
  // bus memory model
  ////////////////////////////////////////

  // any bus output moving between first sight and grant
  function automatic logic request_changed();
    return !data_req_o || (data_addr_o !== held_addr) || (data_we_o !== held_we) ||
           (data_be_o !== held_be) || (data_wdata_o !== held_wdata);
  endfunction

  initial begin : bus_model
    logic [31:0] delay;
    logic [31:0] rsp_data;
    logic        hit_err;
    int          idx;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    data_err_i     = 1'b0;
    acc_count      = 0;
    bus_fail_count = 0;
    bus_lfsr_q     = LfsrSeed;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {fill_byte(10'(4*i+3)), fill_byte(10'(4*i+2)),
                fill_byte(10'(4*i+1)), fill_byte(10'(4*i))};
    end
    forever begin
      @(posedge clk_i);
      if (rst_ni && data_req_o) begin
        held_addr  = data_addr_o;
        held_we    = data_we_o;
        held_be    = data_be_o;
        held_wdata = data_wdata_o;
        // 0 to 3 wait states before the grant
        draw_bits(bus_lfsr_q, 2, delay);
        repeat (delay) begin
          @(posedge clk_i);
          if (request_changed()) begin
            bus_fail_count++;
            $display("%s: bus request changed while waiting for grant", test_name);
          end
        end
        data_gnt_i <= 1'b1;
        @(posedge clk_i);
        data_gnt_i <= 1'b0;
        if (request_changed()) begin
          bus_fail_count++;
          $display("%s: bus request not held through the grant", test_name);
        end
        acc_addr[acc_count % AccLogDepth] = held_addr;
        acc_be[acc_count % AccLogDepth]   = held_be;
        acc_we[acc_count % AccLogDepth]   = held_we;
        acc_count++;
        // word addresses 0x300 to 0x33f answer with an error
        hit_err = (held_addr[31:6] == 26'hc);
        idx     = int'(held_addr[9:2]);
        if (!hit_err && held_we) begin
          for (int i = 0; i < 4; i++) begin
            if (held_be[i]) begin
              mem[idx][8*i +: 8] = held_wdata[8*i +: 8];
            end
          end
        end
        rsp_data = hit_err ? 32'h0 : mem[idx];
        // 0 to 3 wait states before the response
        draw_bits(bus_lfsr_q, 2, delay);
        repeat (delay) begin
          @(posedge clk_i);
          if (data_req_o) begin
            bus_fail_count++;
            $display("%s: second bus request while one is outstanding", test_name);
          end
        end
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= rsp_data;
        data_err_i    <= hit_err;
        @(posedge clk_i);
        if (data_req_o) begin
          bus_fail_count++;
          $display("%s: bus request raised during the response", test_name);
        end
        data_rvalid_i <= 1'b0;
        data_rdata_i  <= '0;
        data_err_i    <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // run control
  ////////////////////////////////////////

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : stimulus
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_type_i     = LSU_WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_addr_i     = '0;
    lsu_wdata_i    = '0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_name      = "startup";
    stim_lfsr_q    = LfsrSeed;
    // reference starts equal to the memory model
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = fill_byte(10'(i));
    end
    wait (rst_ni === 1'b1);
    reset_values();
    aligned_word();
    sub_word_access();
    split_access();
    random_traffic();
    error_responses();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors + bus_fail_count);
    if (errors + bus_fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
source/lsu_pkg.sv
source/lsu_wdata_align.sv
source/lsu_rdata_align.sv
source/lsu_ctrl_fsm.sv
source/lsu_top.sv
dv/tb_clk_gen.sv
dv/tb_lsu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the load/store unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_lsu_top \
  -f sources.f \
  -o sim_lsu

./obj_dir/sim_lsu | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run_sim: simulation passed"
else
  echo "run_sim: simulation failed"
  exit 1
fi
